/* byte_packer_top.f */
pack_pkg.sv
word_gather.sv
mc_block_port.sv
byte_packer_top.sv
byte_packer_chk.sv
byte_packer_tb.sv

/* Bender.yml */
package:
  name: byte_packer

sources:
  # RTL in compile order
  - pack_pkg.sv
  - word_gather.sv
  - mc_block_port.sv
  - byte_packer_top.sv
  # Checker and testbench
  - target: simulation
    files:
      - byte_packer_chk.sv
      - byte_packer_tb.sv

/* byte_packer_tb.sv */
// Byte packer testbench
// Table of cases with a byte queue model, block and counter checks per case
`timescale 1ns/1ps
`default_nettype none

module byte_packer_tb
    import pack_pkg::*;
();

    localparam int CHAIN_CAP = 37;      // Port 16, stage two 16, stage one 4, pending 1
    localparam int BLK_BYTES = 16;
    localparam int WAIT_MAX  = 400;     // Cycles per wait loop
    localparam int N_CASES   = 7;

    typedef struct {
        string name;
        int    nbytes;      // Bytes sent in this case
        bit    reads;       // Microcontroller reads while bytes flow
        int    gap;         // Idle cycles after each byte
        bit    flush_first; // mc_reset pulse before sending
    } case_t;

    logic         clk;
    logic         resetn;
    pkt_byte_t    in_byte;
    logic         in_wr;
    logic         rd_ok;
    logic         mc_reset;
    logic         in_stall;
    pkt_block_t   blk_data;
    logic         blk_ready;
    pack_status_t status;

    case_t       cases [N_CASES];
    pkt_byte_t   model_q [$];   // Accepted bytes not yet read, oldest first
    logic [31:0] rng;
    int          err_cnt;
    int          timeout_cnt;
    int          exp_blocks;
    int          exp_drops;

    byte_packer_top #(
        .ITEMS_PER_STAGE (GATHER_N)
    ) dut (
        .clk       (clk),
        .resetn    (resetn),
        .in_byte   (in_byte),
        .in_wr     (in_wr),
        .rd_ok     (rd_ok),
        .mc_reset  (mc_reset),
        .in_stall  (in_stall),
        .blk_data  (blk_data),
        .blk_ready (blk_ready),
        .status    (status)
    );

    // Handshake checker in both gather stages
    bind word_gather byte_packer_chk chk_gather (
        .clk    (clk),
        .resetn (resetn),
        .wr     (wr),
        .rel    (rel),
        .flush  (flush),
        .full   (full),
        .accept (accept),
        .stall  (stall),
        .drop   (drop)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic pkt_byte_t next_byte();
        rng = xorshift32(rng);
        return rng[7:0];
    endfunction

    // Compare the port against the next 16 model bytes, byte 0 in word 0 element 0
    task automatic check_block(input string name);
        pkt_block_t exp;
        int         w;
        int         b;
        if (model_q.size() < BLK_BYTES)
        begin
            err_cnt++;
            $display("%s: block delivered while the model holds only %0d bytes",
                     name, model_q.size());
        end
        else
        begin
            for (w = 0; w < GATHER_N; w++)
                for (b = 0; b < GATHER_N; b++)
                    exp[w][b] = model_q.pop_front();
            exp_blocks++;
            if (blk_data !== exp)
            begin
                err_cnt++;
                $display("error %s block %0d: expected %h actual %h",
                         name, exp_blocks, exp, blk_data);
            end
        end
    endtask

    // One clock, inputs driven 1 ns after the edge; reads any ready block
    task automatic drive_cycle(input logic wr, input pkt_byte_t b, input bit reads,
                               input string name);
        @(posedge clk);
        #1;
        in_wr   = wr;
        in_byte = b;
        rd_ok   = 1'b0;
        if (reads && blk_ready)
        begin
            check_block(name);
            rd_ok = 1'b1;       // Block taken, port may reload at once
        end
    endtask

    task automatic do_flush(input string name);
        @(posedge clk);
        #1;
        in_wr    = 1'b0;
        rd_ok    = 1'b0;
        mc_reset = 1'b1;
        @(posedge clk);
        #1;
        mc_reset = 1'b0;
        model_q.delete();       // Partial data is gone
        if (blk_ready !== 1'b0)
        begin
            err_cnt++;
            $display("error %s blk_ready after flush: expected 0 actual %b", name, blk_ready);
        end
        if (in_stall !== 1'b0)
        begin
            err_cnt++;
            $display("error %s in_stall after flush: expected 0 actual %b", name, in_stall);
        end
    endtask

    // Read until fewer than 16 model bytes remain
    task automatic drain_blocks(input string name);
        int n;
        n = 0;
        while (model_q.size() >= BLK_BYTES && n < WAIT_MAX)
        begin
            drive_cycle(1'b0, 8'h00, 1'b1, name);
            n++;
        end
        if (model_q.size() >= BLK_BYTES)
        begin
            timeout_cnt++;
            $display("%s: timed out waiting for blk_ready", name);
        end
    endtask

    // rd_ok with no block in the port must not count
    task automatic stray_read(input string name);
        int n;
        n = 0;
        while (blk_ready && n < WAIT_MAX)
        begin
            drive_cycle(1'b0, 8'h00, 1'b0, name);
            n++;
        end
        if (blk_ready)
        begin
            timeout_cnt++;
            $display("%s: timed out waiting for blk_ready to fall", name);
        end
        else
        begin
            @(posedge clk);
            #1;
            in_wr = 1'b0;       // Ends a burst that had no idle cycle
            rd_ok = 1'b1;
            @(posedge clk);
            #1;
            rd_ok = 1'b0;
            if (status.blk_count !== 16'(exp_blocks))
            begin
                err_cnt++;
                $display("error %s idle read blk_count: expected %0d actual %0d",
                         name, exp_blocks, status.blk_count);
            end
        end
    endtask

    task automatic run_case(input case_t c);
        pkt_byte_t b;
        int        i;
        int        n;
        logic      exp_stall;
        if (c.flush_first)
            do_flush(c.name);
        for (i = 0; i < c.nbytes; i++)
        begin
            b = next_byte();
            drive_cycle(1'b1, b, c.reads, c.name);
            // With spacing the chain settles, so only a full chain loses bytes
            if (model_q.size() < CHAIN_CAP)
                model_q.push_back(b);
            else
                exp_drops++;
            repeat (c.gap)
                drive_cycle(1'b0, 8'h00, c.reads, c.name);
        end
        if (!c.reads)
        begin
            n = 0;
            while (status.drop_count !== 16'(exp_drops) && n < WAIT_MAX)
            begin
                drive_cycle(1'b0, 8'h00, 1'b0, c.name);
                n++;
            end
            if (n == WAIT_MAX)
            begin
                timeout_cnt++;
                $display("%s: timed out waiting for drop_count to settle", c.name);
            end
            exp_stall = (model_q.size() >= CHAIN_CAP);
            if (in_stall !== exp_stall)
            begin
                err_cnt++;
                $display("error %s in_stall: expected %b actual %b", c.name, exp_stall, in_stall);
            end
        end
        drain_blocks(c.name);
        stray_read(c.name);
        if (status.blk_count !== 16'(exp_blocks))
        begin
            err_cnt++;
            $display("error %s blk_count: expected %0d actual %0d",
                     c.name, exp_blocks, status.blk_count);
        end
        if (status.drop_count !== 16'(exp_drops))
        begin
            err_cnt++;
            $display("error %s drop_count: expected %0d actual %0d",
                     c.name, exp_drops, status.drop_count);
        end
    endtask

    initial
    begin
        int k;
        int sva_cnt;
        in_byte     = '0;
        in_wr       = 1'b0;
        rd_ok       = 1'b0;
        mc_reset    = 1'b0;
        resetn      = 1'b0;
        rng         = 32'd91500;
        err_cnt     = 0;
        timeout_cnt = 0;
        exp_blocks  = 0;
        exp_drops   = 0;

        // name, bytes, reads, gap, flush first
        cases[0] = '{"ordering",     48, 1'b1, 2, 1'b0};
        cases[1] = '{"dense",        32, 1'b1, 1, 1'b0};    // Word leaves stage one in the gap
        cases[2] = '{"overflow",     41, 1'b0, 1, 1'b0};    // 37 held, 4 lost
        cases[3] = '{"back_to_back",  5, 1'b1, 0, 1'b1};    // Fifth byte waits in the pending slot
        cases[4] = '{"burst_fill",   11, 1'b1, 1, 1'b0};    // Completes the burst's block
        cases[5] = '{"partial",       7, 1'b1, 2, 1'b0};
        cases[6] = '{"flush_fresh",  16, 1'b1, 1, 1'b1};

        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;
        if (blk_ready !== 1'b0 || in_stall !== 1'b0 || status !== '0)
        begin
            err_cnt++;
            $display("error reset: expected idle outputs, got blk_ready %b in_stall %b status %h",
                     blk_ready, in_stall, status);
        end

        for (k = 0; k < N_CASES; k++)
            run_case(cases[k]);

        sva_cnt = dut.u_byte_stage.chk_gather.fail_cnt + dut.u_word_stage.chk_gather.fail_cnt;
        $display("closing: %0d check errors, %0d timeouts, %0d assertion failures",
                 err_cnt, timeout_cnt, sva_cnt);
        if (err_cnt == 0 && timeout_cnt == 0 && sva_cnt == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* byte_packer_chk.sv */
// Gather stage checker
// Concurrent assertions on the full, accept, pending and drop handshake of one stage
`timescale 1ns/1ps
`default_nettype none

module byte_packer_chk (
    input wire logic clk,
    input wire logic resetn,
    input wire logic wr,
    input wire logic rel,
    input wire logic flush,
    input wire logic full,
    input wire logic accept,
    input wire logic stall,     // Pending slot occupied
    input wire logic drop
);

    int fail_cnt = 0;   // Summed by the testbench at the end of the run

    // Full only rises after an item was stored
    full_after_accept: assert property (
        @(posedge clk) disable iff (!resetn)
        $rose(full) |-> $past(accept)
    )
    else
    begin
        fail_cnt++;
        $error("full rose without an accepted item");
    end

    // A lost write always meets an occupied pending slot
    drop_needs_pending: assert property (
        @(posedge clk) disable iff (!resetn)
        drop |-> (wr && stall)
    )
    else
    begin
        fail_cnt++;
        $error("drop raised without a write and a pending item");
    end

    // Nothing is stored into a full register
    no_accept_when_full: assert property (
        @(posedge clk) disable iff (!resetn)
        accept |-> !full
    )
    else
    begin
        fail_cnt++;
        $error("item accepted while the stage was full");
    end

    // Release of a full stage empties it one cycle later
    rel_clears_full: assert property (
        @(posedge clk) disable iff (!resetn)
        (full && rel) |=> !full
    )
    else
    begin
        fail_cnt++;
        $error("stage still full after release");
    end

    // Flush empties the stage one cycle later
    flush_clears: assert property (
        @(posedge clk) disable iff (!resetn)
        flush |=> (!full && !stall)
    )
    else
    begin
        fail_cnt++;
        $error("stage still full or pending after flush");
    end

endmodule

`default_nettype wire

/* byte_packer_top.sv */
// Byte packer top level
// Byte stage -> word stage -> microcontroller port
`timescale 1ns/1ps
`default_nettype none

module byte_packer_top
    import pack_pkg::*;
#(
    // Only GATHER_N (4) matches the package types
    parameter int ITEMS_PER_STAGE = GATHER_N
) (
    input  wire logic       clk,
    input  wire logic       resetn,
    input  wire pkt_byte_t  in_byte,
    input  wire logic       in_wr,
    input  wire logic       rd_ok,
    input  wire logic       mc_reset,
    output logic            in_stall,
    output pkt_block_t      blk_data,
    output logic            blk_ready,
    output pack_status_t    status
);

    logic      byte_full;   // Word ready in stage one
    logic      byte_drop;
    pkt_word_t byte_data;
    logic      word_acc;    // Stage two took the word
    logic      word_full;   // Block ready in stage two
    pkt_block_t word_data;
    logic      port_take;

    // Bytes into words
    word_gather #(
        .item_t (pkt_byte_t),
        .N      (ITEMS_PER_STAGE)
    ) u_byte_stage (
        .clk    (clk),
        .resetn (resetn),
        .wr     (in_wr),
        .item   (in_byte),
        .rel    (word_acc),
        .flush  (mc_reset),
        .full   (byte_full),
        .accept (),
        .stall  (in_stall),
        .drop   (byte_drop),
        .data   (byte_data)
    );

    // Words into blocks, full level of stage one is the write
    word_gather #(
        .item_t (pkt_word_t),
        .N      (ITEMS_PER_STAGE)
    ) u_word_stage (
        .clk    (clk),
        .resetn (resetn),
        .wr     (byte_full),
        .item   (byte_data),
        .rel    (port_take),
        .flush  (mc_reset),
        .full   (word_full),
        .accept (word_acc),
        .stall  (),
        .drop   (),
        .data   (word_data)
    );

    mc_block_port u_port (
        .clk       (clk),
        .resetn    (resetn),
        .blk_full  (word_full),
        .blk_in    (word_data),
        .rd_ok     (rd_ok),
        .flush     (mc_reset),
        .drop      (byte_drop),
        .take      (port_take),
        .blk_data  (blk_data),
        .blk_ready (blk_ready),
        .status    (status)
    );

endmodule

`default_nettype wire

/* mc_block_port.sv */
// Microcontroller block port
// Holds the finished block until read, releases the gather stage and keeps counters
`timescale 1ns/1ps
`default_nettype none

module mc_block_port
    import pack_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       resetn,
    input  wire logic       blk_full,   // Second stage holds a complete block
    input  wire pkt_block_t blk_in,
    input  wire logic       rd_ok,      // Microcontroller has read blk_data
    input  wire logic       flush,
    input  wire logic       drop,       // Byte lost in the first stage
    output logic            take,       // Release the second stage
    output pkt_block_t      blk_data,
    output logic            blk_ready,
    output pack_status_t    status
);

    logic         rd_hit;       // Read of a valid block
    pack_status_t cnt;

    // Load when the port is free or being read in this very cycle
    assign take   = blk_full && (!blk_ready || rd_ok) && !flush;
    assign rd_hit = rd_ok && blk_ready;
    assign status = cnt;

    // Ready level
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            blk_ready <= 1'b0;
        else if (flush)
            blk_ready <= 1'b0;      // Port cleared, partial data gone
        else if (take)
            blk_ready <= 1'b1;      // New block overrides a read
        else if (rd_hit)
            blk_ready <= 1'b0;
    end

    // Counters survive flush, saturate at max
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            cnt <= '0;
        else
        begin
            if (rd_hit && (cnt.blk_count != 16'hffff))
                cnt.blk_count <= cnt.blk_count + 16'd1;
            if (drop && (cnt.drop_count != 16'hffff))
                cnt.drop_count <= cnt.drop_count + 16'd1;
        end
    end

    // Block copy seen by the microcontroller
    always_ff @(posedge clk)
    begin
        if (take)
            blk_data <= blk_in;
    end

endmodule

`default_nettype wire

/* word_gather.sv */
// Gather stage
// Packs N items of one payload type into a wide register, flags it full
// and holds at most one write that arrives while full
`timescale 1ns/1ps
`default_nettype none

module word_gather #(
    parameter type item_t = logic [7:0],
    parameter int  N      = 4
) (
    input  wire logic             clk,
    input  wire logic             resetn,
    input  wire logic             wr,       // Write strobe (or level from previous stage)
    input  wire item_t            item,
    input  wire logic             rel,      // Consumer has taken the content
    input  wire logic             flush,    // Discard everything
    output logic                  full,
    output logic                  accept,   // Item stored this cycle
    output logic                  stall,    // Pending slot occupied
    output logic                  drop,     // Write lost this cycle
    output item_t [N-1:0]         data
);

    localparam int IW = (N > 1) ? $clog2(N) : 1;

    logic [IW-1:0] idx;         // Next slot to fill
    logic          pend;        // One write held while full
    item_t         pend_item;
    logic          store;       // An item goes into the register
    item_t         store_item;
    logic          last;        // Store fills the final slot

    // Pending write drains first so arrival order is kept
    assign store      = !full && (pend || wr) && !flush;
    assign store_item = pend ? pend_item : item;
    assign last       = (idx == IW'(N - 1));

    assign accept = store;
    assign stall  = pend;

    // A write meeting an occupied pending slot is lost, also in the drain cycle
    assign drop = wr && pend && !flush;

    // Control state
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            full <= 1'b0;
            idx  <= '0;
            pend <= 1'b0;
        end
        else if (flush)
        begin
            full <= 1'b0;       // Flush wins over rel, writes and pending
            idx  <= '0;
            pend <= 1'b0;
        end
        else
        begin
            if (store)
            begin
                if (last)
                begin
                    full <= 1'b1;   // Nth item, visible next cycle
                    idx  <= '0;
                end
                else
                    idx <= idx + 1'b1;
            end
            else if (full && rel)
                full <= 1'b0;

            // Hold one write seen while full
            if (wr && full && !pend)
                pend <= 1'b1;
            else if (store && pend)
                pend <= 1'b0;   // Drained into the register
        end
    end

    // Payload registers, no reset needed
    always_ff @(posedge clk)
    begin
        if (store)
            data[idx] <= store_item;    // Oldest item lands in element 0
        if (wr && full && !pend)
            pend_item <= item;
    end

endmodule

`default_nettype wire

/* pack_pkg.sv */
// Byte packer shared types
// Byte, word and block payloads plus the status counters seen by the microcontroller
`default_nettype none

package pack_pkg;

    // Items per gather stage; the payload types below are built for this value
    localparam int GATHER_N = 4;

    // One data byte from the source
    typedef logic [7:0] pkt_byte_t;

    // Four bytes, element 0 is the first byte received
    typedef pkt_byte_t [GATHER_N-1:0] pkt_word_t;

    // Four words = 16 bytes, byte 0 first
    typedef pkt_word_t [GATHER_N-1:0] pkt_block_t;

    // Counters reported to the microcontroller
    typedef struct packed {
        logic [15:0] blk_count;     // Blocks read by the microcontroller
        logic [15:0] drop_count;    // Bytes lost to overflow
    } pack_status_t;

endpackage

`default_nettype wire
